// File: Bender.yml
package:
  name: fe_frontend

sources:
  - src/fe_pkg.sv
  - src/fetch_stage.sv
  - src/stage_pipe.sv
  - src/decode_stage.sv
  - src/branch_predictor.sv
  - src/fe_top.sv
  - target: simulation
    files:
      - sim/fe_asserts.sv
      - sim/fe_tb.sv

// File: compile.f
src/fe_pkg.sv
src/fetch_stage.sv
src/stage_pipe.sv
src/decode_stage.sv
src/branch_predictor.sv
src/fe_top.sv
sim/fe_asserts.sv
sim/fe_tb.sv

// File: sim/fe_asserts.sv
`timescale 1ns/1ps

module fe_asserts import fe_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    ready_i,
  input word_t   imem_addr_o,
  input logic    dec_valid_o,
  input word_t   dec_pc_o,
  input opcode_t dec_opcode_o,
  input word_t   dec_src2_imm_o,
  input fu_t     dec_fu_o,
  input logic    dec_pred_taken_o
);

  // nothing leaves the front end while reset is held
  valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !dec_valid_o)
    else $error("dec_valid_o high during reset");

  addr_even: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_addr_o[0] == 1'b0)
    else $error("odd instruction address");

  // a stalled edge keeps the output register
  hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ready_i |=> $stable(dec_valid_o) && $stable(dec_pc_o) &&
                 $stable(dec_opcode_o) && $stable(dec_src2_imm_o))
    else $error("outputs changed during stall");

  redirect_is_branch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_pred_taken_o |-> dec_valid_o && dec_fu_o == FU_BRANCH)
    else $error("redirect without a valid branch");

endmodule

bind fe_top fe_asserts i_asserts (.*);

// File: sim/fe_tb.sv
`timescale 1ns/1ps

module fe_tb import fe_pkg::*; ();

  localparam int    NUM_ACC = 24;
  localparam int    TIMEOUT = 200;
  localparam word_t BCC_PC  = 16'h0010;

  logic    clk_i;
  logic    rst_n_i;
  logic    ready_i;
  word_t   imem_data_i;
  logic    bht_upd_v_i;
  word_t   bht_upd_pc_i;
  logic    bht_upd_taken_i;
  word_t   imem_addr_o;
  logic    dec_valid_o;
  word_t   dec_pc_o;
  opcode_t dec_opcode_o;
  fu_t     dec_fu_o;
  logic    dec_we_o;
  reg_id_t dec_dest_o;
  reg_id_t dec_src1_o;
  word_t   dec_src2_imm_o;
  logic    dec_use_imm_o;
  cond_t   dec_cond_o;
  logic    dec_illegal_o;
  logic    dec_pred_taken_o;

  word_t  imem [256];
  ctr_t   model_ctr [BHT_ENTRIES];
  word_t  exp_pc [$];
  logic   exp_taken [$];
  int     ready_mode;
  logic   ready_d;
  integer seed = 32'h5bc;

  // columns: random ready, taken updates, then not-taken updates
  int phase_tbl [7][3] = '{'{0, 0, 0}, '{0, 2, 0}, '{0, 2, 2}, '{0, 4, 1},
                           '{0, 0, 3}, '{1, 2, 0}, '{1, 0, 0}};

  // add, sub, and, addi -3, load -32, store +31, two illegal,
  // bcc to 0x16, addi, add, b back to 0
  word_t prog [12] = '{16'h0298, 16'h1FA8, 16'h283F, 16'h347D, 16'h4760, 16'h5C9F,
                       16'h9ABC, 16'hF123, 16'h6503, 16'h3241, 16'h0B18, 16'h7FF5};

  fe_top i_dut (.*);

  // combinational instruction memory
  assign imem_data_i = imem[imem_addr_o[8:1]];

  always #5 clk_i = ~clk_i;

  // mode 0 holds ready low, 1 high, 2 random
  always @(posedge clk_i) begin
    if (ready_mode == 2)
      ready_d = $random(seed);
    else
      ready_d = (ready_mode == 1);
    #1;
    ready_i = ready_d;
  end

  task automatic check(input string what, input logic [15:0] act, input logic [15:0] exp);
    if (act !== exp) begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, act, exp);
      $display("TEST FAILED");
      $fatal(1, "wrong value");
    end
  endtask

  function automatic word_t branch_offset(input word_t ins);
    if (ins[15:12] == OP_BCC)
      return word_t'(2 * $signed(ins[7:0]));
    return word_t'(2 * $signed(ins[11:0]));
  endfunction

  // one predictor strobe on the bcc slot, mirrored in the model
  task automatic train_counter(input logic taken);
    bht_idx_t idx;
    idx = BCC_PC[6:1];
    bht_upd_v_i = 1'b1;
    bht_upd_pc_i = BCC_PC;
    bht_upd_taken_i = taken;
    @(posedge clk_i);
    #1;
    bht_upd_v_i = 1'b0;
    if (taken && model_ctr[idx] != 2'b11)
      model_ctr[idx] = model_ctr[idx] + 2'd1;
    else if (!taken && model_ctr[idx] != 2'b00)
      model_ctr[idx] = model_ctr[idx] - 2'd1;
  endtask

  // walk the program along the predicted path
  task automatic build_expected();
    word_t pc;
    word_t ins;
    logic  taken;
    pc = RESET_PC;
    exp_pc.delete();
    exp_taken.delete();
    for (int k = 0; k < NUM_ACC; k++) begin
      ins = imem[pc[8:1]];
      taken = (ins[15:12] == OP_B) || (ins[15:12] == OP_BCC && model_ctr[pc[6:1]][1]);
      exp_pc.push_back(pc);
      exp_taken.push_back(taken);
      pc = taken ? pc + branch_offset(ins) : pc + 16'd2;
    end
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!(dec_valid_o && ready_i)) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("error at %0d ns: no instruction arrived within %0d cycles", $time, TIMEOUT);
        $display("TEST FAILED");
        $fatal(1, "timeout");
      end else begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic check_instr(input word_t pc, input logic taken);
    word_t   ins;
    opcode_t op;
    logic    imm_op;
    fu_t     fu;
    ins = imem[pc[8:1]];
    op = ins[15:12];
    imm_op = (op == OP_ADDI) || (op == OP_LOAD) || (op == OP_STORE);
    fu = (op == OP_LOAD || op == OP_STORE) ? FU_MEM :
         (op == OP_BCC || op == OP_B) ? FU_BRANCH : FU_ALU;
    check("pc", dec_pc_o, pc);
    check("opcode", dec_opcode_o, op);
    check("unit", dec_fu_o, fu);
    check("dest", dec_dest_o, ins[11:9]);
    check("src1", dec_src1_o, ins[8:6]);
    check("write enable", dec_we_o, op <= OP_LOAD);
    check("illegal", dec_illegal_o, op > OP_B);
    check("use imm", dec_use_imm_o, imm_op);
    check("predicted taken", dec_pred_taken_o, taken);
    if (imm_op)
      check("immediate", dec_src2_imm_o, word_t'($signed(ins[5:0])));
    else if (op <= OP_AND)
      check("src2", dec_src2_imm_o, ins[5:3]);
    if (op == OP_BCC)
      check("cond", dec_cond_o, ins[11:8]);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    ready_i = 1'b0;
    ready_mode = 0;
    bht_upd_v_i = 1'b0;
    bht_upd_pc_i = '0;
    bht_upd_taken_i = 1'b0;
    // plain adds whose fields follow the address, program on top
    for (int i = 0; i < 256; i++)
      imem[i] = word_t'(i);
    for (int i = 0; i < 12; i++)
      imem[i] = prog[i];

    for (int p = 0; p < 7; p++) begin
      ready_mode = 0;
      rst_n_i = 1'b0;
      repeat (16) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      for (int i = 0; i < BHT_ENTRIES; i++)
        model_ctr[i] = CTR_RESET;
      // train while stalled so nothing moves yet
      for (int i = 0; i < phase_tbl[p][1]; i++)
        train_counter(1'b1);
      for (int i = 0; i < phase_tbl[p][2]; i++)
        train_counter(1'b0);
      build_expected();
      ready_mode = phase_tbl[p][0] ? 2 : 1;
      for (int k = 0; k < NUM_ACC; k++) begin
        wait_accept();
        check_instr(exp_pc[k], exp_taken[k]);
      end
      @(posedge clk_i);
      #1;
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import fe_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  valid_i,
  input  word_t pc_i,
  input  logic  is_branch_i,
  input  logic  is_cond_i,
  input  word_t offset_i,
  input  logic  upd_v_i,
  input  word_t upd_pc_i,
  input  logic  upd_taken_i,
  output logic  redirect_o,
  output word_t target_o
);

  ctr_t     bht_q [BHT_ENTRIES];
  bht_idx_t lookup_idx;
  bht_idx_t upd_idx;
  ctr_t     lookup_ctr;
  ctr_t     upd_ctr;
  ctr_t     upd_ctr_next;

  // bit 0 of pc is always zero
  assign lookup_idx = pc_i[BHT_IDX_W:1];
  assign upd_idx    = upd_pc_i[BHT_IDX_W:1];

  assign lookup_ctr = bht_q[lookup_idx];
  assign upd_ctr    = bht_q[upd_idx];

  // saturating step
  always_comb begin
    upd_ctr_next = upd_ctr;
    if (upd_taken_i && upd_ctr != 2'b11) begin
      upd_ctr_next = upd_ctr + 1'b1;
    end else if (!upd_taken_i && upd_ctr != 2'b00) begin
      upd_ctr_next = upd_ctr - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        bht_q[i] <= CTR_RESET;
      end
    end else if (upd_v_i) begin
      bht_q[upd_idx] <= upd_ctr_next;
    end
  end

  // B always taken, BCC follows counter msb
  assign redirect_o = valid_i & is_branch_i & (~is_cond_i | lookup_ctr[CTR_W-1]);
  assign target_o   = pc_i + offset_i;

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import fe_pkg::*; (
  input  word_t   instr_i,
  output opcode_t opcode_o,
  output fu_t     fu_o,
  output logic    we_o,
  output reg_id_t dest_o,
  output reg_id_t src1_o,
  output word_t   src2_imm_o,
  output logic    use_imm_o,
  output cond_t   cond_o,
  output logic    illegal_o,
  output logic    is_branch_o,
  output logic    is_cond_o,
  output word_t   offset_o
);

  word_t imm6_sext;
  word_t src2_zext;
  word_t off_bcc;
  word_t off_b;

  // fixed field positions
  assign opcode_o = instr_i[15:12];
  assign dest_o   = instr_i[11:9];
  assign src1_o   = instr_i[8:6];

  assign imm6_sext = {{(WORD_W-6){instr_i[5]}}, instr_i[5:0]};
  assign src2_zext = {{(WORD_W-REG_ID_W){1'b0}}, instr_i[5:3]};

  // branch offsets are in halfwords, shifted to bytes
  assign off_bcc = {{(WORD_W-9){instr_i[7]}}, instr_i[7:0], 1'b0};
  assign off_b   = {{(WORD_W-13){instr_i[11]}}, instr_i[11:0], 1'b0};

  always_comb begin
    fu_o        = FU_ALU;
    we_o        = 1'b0;
    src2_imm_o  = '0;
    use_imm_o   = 1'b0;
    cond_o      = '0;
    illegal_o   = 1'b0;
    is_branch_o = 1'b0;
    is_cond_o   = 1'b0;
    offset_o    = '0;

    case (opcode_o)
      OP_ADD, OP_SUB, OP_AND: begin
        we_o       = 1'b1;
        src2_imm_o = src2_zext;
      end
      OP_ADDI: begin
        we_o       = 1'b1;
        src2_imm_o = imm6_sext;
        use_imm_o  = 1'b1;
      end
      OP_LOAD: begin
        fu_o       = FU_MEM;
        we_o       = 1'b1;
        src2_imm_o = imm6_sext;
        use_imm_o  = 1'b1;
      end
      OP_STORE: begin
        // store data comes from dest field, no writeback
        fu_o       = FU_MEM;
        src2_imm_o = imm6_sext;
        use_imm_o  = 1'b1;
      end
      OP_BCC: begin
        fu_o        = FU_BRANCH;
        cond_o      = instr_i[11:8];
        is_branch_o = 1'b1;
        is_cond_o   = 1'b1;
        offset_o    = off_bcc;
      end
      OP_B: begin
        fu_o        = FU_BRANCH;
        is_branch_o = 1'b1;
        offset_o    = off_b;
      end
      default: begin
        // unknown code, treated as a dead alu op
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: src/fe_pkg.sv
package fe_pkg;

  // basic widths
  localparam int WORD_W   = 16;
  localparam int REG_ID_W = 3;
  localparam int OPCODE_W = 4;
  localparam int FU_W     = 2;
  localparam int COND_W   = 4;
  localparam int CTR_W    = 2;

  // branch history table
  localparam int BHT_ENTRIES = 64;
  localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_ID_W-1:0]  reg_id_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [FU_W-1:0]      fu_t;
  typedef logic [COND_W-1:0]    cond_t;
  typedef logic [CTR_W-1:0]     ctr_t;
  typedef logic [BHT_IDX_W-1:0] bht_idx_t;

  // major opcodes, instr[15:12]
  localparam opcode_t OP_ADD   = 4'h0;
  localparam opcode_t OP_SUB   = 4'h1;
  localparam opcode_t OP_AND   = 4'h2;
  localparam opcode_t OP_ADDI  = 4'h3;
  localparam opcode_t OP_LOAD  = 4'h4;
  localparam opcode_t OP_STORE = 4'h5;
  localparam opcode_t OP_BCC   = 4'h6;
  localparam opcode_t OP_B     = 4'h7;

  // functional units
  localparam fu_t FU_ALU    = 2'd0;
  localparam fu_t FU_MEM    = 2'd1;
  localparam fu_t FU_BRANCH = 2'd2;

  // weakly not taken
  localparam ctr_t CTR_RESET = 2'b01;

  localparam word_t RESET_PC = 16'h0000;

  // fetch/decode register: pc and instruction
  localparam int FD_W = 2 * WORD_W;

  // decode/branch register: pc, src2_imm, offset, opcode, fu, dest, src1, cond
  // plus we, use_imm, illegal, is_branch, is_cond
  localparam int DB_W = 3 * WORD_W + OPCODE_W + FU_W + 2 * REG_ID_W + COND_W + 5;

endpackage

// File: src/fe_top.sv
`timescale 1ns/1ps

module fe_top import fe_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    ready_i,
  input  word_t   imem_data_i,
  input  logic    bht_upd_v_i,
  input  word_t   bht_upd_pc_i,
  input  logic    bht_upd_taken_i,
  output word_t   imem_addr_o,
  output logic    dec_valid_o,
  output word_t   dec_pc_o,
  output opcode_t dec_opcode_o,
  output fu_t     dec_fu_o,
  output logic    dec_we_o,
  output reg_id_t dec_dest_o,
  output reg_id_t dec_src1_o,
  output word_t   dec_src2_imm_o,
  output logic    dec_use_imm_o,
  output cond_t   dec_cond_o,
  output logic    dec_illegal_o,
  output logic    dec_pred_taken_o
);

  logic stall;
  logic flush;
  logic redirect;
  word_t target;
  word_t fetch_pc;

  // fetch/decode register
  logic  fd_valid;
  word_t fd_pc;
  word_t fd_instr;

  // decode outputs
  opcode_t d_opcode;
  fu_t     d_fu;
  logic    d_we;
  reg_id_t d_dest;
  reg_id_t d_src1;
  word_t   d_src2_imm;
  logic    d_use_imm;
  cond_t   d_cond;
  logic    d_illegal;
  logic    d_is_branch;
  logic    d_is_cond;
  word_t   d_offset;

  // decode/branch register
  logic  db_is_branch;
  logic  db_is_cond;
  word_t db_offset;

  assign stall = ~ready_i;
  // wrong-path drop, held back by stall inside the pipes
  assign flush = redirect;

  fetch_stage i_fetch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall),
    .redirect_i (redirect),
    .target_i   (target),
    .pc_o       (fetch_pc),
    .imem_addr_o(imem_addr_o)
  );

  stage_pipe #(.WIDTH(FD_W)) i_fd_pipe (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .stall_i(stall),
    .flush_i(flush),
    .valid_i(1'b1),
    .data_i ({fetch_pc, imem_data_i}),
    .valid_o(fd_valid),
    .data_o ({fd_pc, fd_instr})
  );

  decode_stage i_decode (
    .instr_i    (fd_instr),
    .opcode_o   (d_opcode),
    .fu_o       (d_fu),
    .we_o       (d_we),
    .dest_o     (d_dest),
    .src1_o     (d_src1),
    .src2_imm_o (d_src2_imm),
    .use_imm_o  (d_use_imm),
    .cond_o     (d_cond),
    .illegal_o  (d_illegal),
    .is_branch_o(d_is_branch),
    .is_cond_o  (d_is_cond),
    .offset_o   (d_offset)
  );

  stage_pipe #(.WIDTH(DB_W)) i_db_pipe (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .stall_i(stall),
    .flush_i(flush),
    .valid_i(fd_valid),
    .data_i ({fd_pc, d_src2_imm, d_offset, d_opcode, d_fu, d_dest, d_src1, d_cond,
              d_we, d_use_imm, d_illegal, d_is_branch, d_is_cond}),
    .valid_o(dec_valid_o),
    .data_o ({dec_pc_o, dec_src2_imm_o, db_offset, dec_opcode_o, dec_fu_o, dec_dest_o,
              dec_src1_o, dec_cond_o, dec_we_o, dec_use_imm_o, dec_illegal_o,
              db_is_branch, db_is_cond})
  );

  branch_predictor i_bp (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (dec_valid_o),
    .pc_i       (dec_pc_o),
    .is_branch_i(db_is_branch),
    .is_cond_i  (db_is_cond),
    .offset_i   (db_offset),
    .upd_v_i    (bht_upd_v_i),
    .upd_pc_i   (bht_upd_pc_i),
    .upd_taken_i(bht_upd_taken_i),
    .redirect_o (redirect),
    .target_o   (target)
  );

  // the branch leaves with its own prediction
  assign dec_pred_taken_o = redirect;

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fe_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  stall_i,
  input  logic  redirect_i,
  input  word_t target_i,
  output word_t pc_o,
  output word_t imem_addr_o
);

  word_t pc_q;
  word_t pc_d;
  word_t pc_inc;

  // pc is always even, so only bits above bit 0 need the adder
  assign pc_inc = {pc_q[WORD_W-1:1] + 1'b1, 1'b0};

  // hold beats redirect beats increment
  always_comb begin
    if (stall_i) begin
      pc_d = pc_q;
    end else if (redirect_i) begin
      pc_d = target_i;
    end else begin
      pc_d = pc_inc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o        = pc_q;
  // memory answers in the same cycle
  assign imem_addr_o = pc_q;

endmodule

// File: src/stage_pipe.sv
`timescale 1ns/1ps

module stage_pipe #(
  parameter int WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             stall_i,
  input  logic             flush_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      data_o  <= '0;
    end else if (!stall_i) begin
      // flush only drops the valid bit, payload still moves
      valid_o <= valid_i & ~flush_i;
      data_o  <= data_i;
    end
  end

endmodule
